//--- hw/utxPkg.sv
// texel decode types, format codes, register map and pipeline occupancy enum
`default_nettype none

package utxPkg;

	// payload widths
	typedef logic [63:0] blockWord;
	typedef logic [63:0] texelWord;
	typedef logic [3:0] pixIndex;

	// colour channels
	typedef logic [7:0] chan8;
	typedef logic [4:0] chan5;

	// configuration port
	typedef logic [1:0] cfgAddrT;
	typedef logic [7:0] cfgDataT;

	// format flag carried with each request
	localparam logic fmtUtx1 = 1'b0;
	localparam logic fmtUtx2 = 1'b1;

	// register map
	localparam cfgAddrT addrMode = 2'd0;
	localparam cfgAddrT addrStatus = 2'd1;

	// mode register layout
	localparam int modeUtx2Bit = 0;
	localparam int modeInterpBit = 1;
	localparam cfgDataT modeMask = 8'h03;
	localparam cfgDataT modeResetValue = 8'h03;

	// how many texels the two-stage pipeline currently holds
	typedef enum logic [1:0]
	{
		empty,
		one,
		two
	} pipeState;

endpackage

`default_nettype wire

//--- hw/utxInterp.sv
// utxInterp: 11:5 weighted blend of two 5-bit channels into an 8-bit channel
`timescale 1ns/1ps
`default_nettype none

module utxInterp
	import utxPkg::*;
(
	input wire chan5 near,
	input wire chan5 far,
	output chan8 blend
);

	chan8 nearExp;
	chan8 farExp;
	logic [11:0] weighted;

	// 5-to-8 expansion repeats the top three bits
	assign nearExp = {near, near[4:2]};
	assign farExp = {far, far[4:2]};

	// max is 16 * 255, so twelve bits are enough
	assign weighted = ({4'b0000, nearExp} * 12'd11) + ({4'b0000, farExp} * 12'd5);

	// divide by the total weight of 16
	assign blend = weighted[11:4];

endmodule

`default_nettype wire

//--- hw/utxPixelDecode.sv
// utxPixelDecode: combinational UTX1/UTX2 block decoder returning one texel
`timescale 1ns/1ps
`default_nettype none

module utxPixelDecode
	import utxPkg::*;
(
	input wire blockWord block,
	input wire pixIndex index,
	input wire format,
	input wire utx2Enable,
	input wire interpEnable,
	output texelWord texel
);

	// UTX1 fields, all expanded from 4 bits
	chan8 spread;
	chan8 halfSpread;
	chan8 centreR;
	chan8 centreG;
	chan8 centreB;
	logic utx1Sel;
	logic [31:0] utx1Lo;
	logic [31:0] utx1Hi;

	// UTX2 endpoints and selectors
	logic [15:0] colorA;
	logic [15:0] colorB;
	logic selB;
	logic selA;
	logic alphaMode;
	logic doInterp;
	chan5 endA [3:0];
	chan5 endB [3:0];
	chan8 mixB [3:0];
	chan8 mixA [3:0];
	logic [31:0] loColor;
	logic [31:0] hiColor;
	logic [31:0] towardB;
	logic [31:0] towardA;

	// selected pixel as alpha, red, green, blue
	logic [31:0] pick;

	assign spread = {block[15:12], block[15:12]};
	assign halfSpread = {1'b0, spread[7:1]};
	assign centreR = {block[11:8], block[11:8]};
	assign centreG = {block[7:4], block[7:4]};
	assign centreB = {block[3:0], block[3:0]};

	// selector word sits at bits 31:16
	assign utx1Sel = block[{2'b01, index}];

	assign utx1Lo = {8'hFF, centreR - halfSpread, centreG - halfSpread, centreB - halfSpread};
	assign utx1Hi = {8'hFF, centreR + halfSpread, centreG + halfSpread, centreB + halfSpread};

	assign colorA = block[15:0];
	assign colorB = block[31:16];

	// two-bit selectors start at bit 32, B is the odd bit of each pair
	assign selB = block[{1'b1, index, 1'b1}];
	assign selA = block[{1'b1, index, 1'b0}];

	assign alphaMode = colorA[15];
	assign doInterp = (colorA[15] == colorB[15]) && interpEnable;

	// per channel endpoints, index 3 is alpha
	assign endA = '{{colorA[10], colorA[5], colorA[0], 2'b00},
		colorA[14:10], colorA[9:5], colorA[4:0]};
	assign endB = '{{colorB[10], colorB[5], colorB[0], 2'b00},
		colorB[14:10], colorB[9:5], colorB[4:0]};

	genvar ch;
	generate
		for (ch = 0; ch < 4; ch++)
		begin : gBlend
			utxInterp i_towardB (.near(endB[ch]), .far(endA[ch]), .blend(mixB[ch]));
			utxInterp i_towardA (.near(endA[ch]), .far(endB[ch]), .blend(mixA[ch]));
		end
	endgenerate

	assign towardB = {mixB[3], mixB[2], mixB[1], mixB[0]};
	assign towardA = {mixA[3], mixA[2], mixA[1], mixA[0]};

	// low level from colour B, high level from colour A
	assign loColor = {colorB[10], colorB[5], colorB[0], 5'b00000,
		colorB[14:10], colorB[14:12], colorB[9:5], colorB[9:7], colorB[4:0], colorB[4:2]};
	assign hiColor = {colorA[10], colorA[5], colorA[0], 5'b00000,
		colorA[14:10], colorA[14:12], colorA[9:5], colorA[9:7], colorA[4:0], colorA[4:2]};

	always_comb
	begin
		pick = 32'h0000_0000;
		case (format)
			fmtUtx1:
				pick = utx1Sel ? utx1Hi : utx1Lo;
			fmtUtx2:
			begin
				// a disabled UTX2 request leaves the texel at zero
				if (utx2Enable)
				begin
					if (doInterp)
					begin
						case ({selB, selA})
							2'b00: pick = loColor;
							2'b10: pick = towardB;
							2'b01: pick = towardA;
							default: pick = hiColor;
						endcase
					end
					else
					begin
						// two-level rule, alpha picked by its own selector
						pick[23:0] = selB ? hiColor[23:0] : loColor[23:0];
						pick[31:24] = selA ? hiColor[31:24] : loColor[31:24];
					end
					if (!alphaMode)
						pick[31:24] = 8'hFF;
				end
			end
		endcase
	end

	assign texel = {pick[31:24], pick[31:24], pick[23:16], pick[23:16],
		pick[15:8], pick[15:8], pick[7:0], pick[7:0]};

endmodule

`default_nettype wire

//--- hw/utxModeRegs.sv
// utxModeRegs: mode register and delivered texel counter with readback
`timescale 1ns/1ps
`default_nettype none

module utxModeRegs
	import utxPkg::*;
(
	input wire clock,
	input wire rst,
	input wire cfgWrite,
	input wire cfgAddrT cfgAddr,
	input wire cfgDataT cfgData,
	input wire texDone,
	output cfgDataT cfgReadData,
	output logic utx2Enable,
	output logic interpEnable
);

	cfgDataT modeReg;
	cfgDataT texCount;

	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			modeReg <= modeResetValue;
			texCount <= '0;
		end
		else
		begin
			// status is read-only, only the mode address takes writes
			if (cfgWrite && (cfgAddr == addrMode))
				modeReg <= cfgData & modeMask;
			// wraps at 256
			if (texDone)
				texCount <= texCount + 8'd1;
		end
	end

	assign utx2Enable = modeReg[modeUtx2Bit];
	assign interpEnable = modeReg[modeInterpBit];

	always_comb
	begin
		case (cfgAddr)
			addrMode: cfgReadData = modeReg;
			addrStatus: cfgReadData = texCount;
			default: cfgReadData = '0;
		endcase
	end

	// unused mode bits never become set, whatever was written
	assert property (@(posedge clock) disable iff (rst) (modeReg & ~modeMask) == '0);

endmodule

`default_nettype wire

//--- hw/utxTexelUnit.sv
// utxTexelUnit: two-stage valid/ready texel pipeline around the pixel decoder
`timescale 1ns/1ps
`default_nettype none

module utxTexelUnit
	import utxPkg::*;
(
	input wire clock,
	input wire rst,
	input wire utx2Enable,
	input wire interpEnable,
	input wire reqValid,
	input wire blockWord reqBlock,
	input wire pixIndex reqIndex,
	input wire reqFormat,
	input wire texReady,
	output logic reqReady,
	output logic texValid,
	output texelWord texData,
	output logic texDone
);

	pipeState state;
	pipeState stateNext;
	texelWord decoded;
	texelWord holdReg;
	texelWord outReg;
	logic accept;
	logic deliver;
	logic outFromDec;
	logic outFromHold;
	logic holdFromDec;

	// decode on entry with the mode bits of this cycle
	utxPixelDecode i_utxPixelDecode
	(
		.block(reqBlock),
		.index(reqIndex),
		.format(reqFormat),
		.utx2Enable(utx2Enable),
		.interpEnable(interpEnable),
		.texel(decoded)
	);

	assign texValid = (state != empty);
	assign reqReady = (state != two) || texReady;
	assign accept = reqValid && reqReady;
	assign deliver = texValid && texReady;
	assign texDone = deliver;
	assign texData = outReg;

	always_comb
	begin
		stateNext = state;
		outFromDec = 1'b0;
		outFromHold = 1'b0;
		holdFromDec = 1'b0;
		case (state)
			empty:
			begin
				if (accept)
				begin
					stateNext = one;
					outFromDec = 1'b1;
				end
			end
			one:
			begin
				// straight into the output register when it drains this cycle
				if (accept && deliver)
					outFromDec = 1'b1;
				else if (accept)
				begin
					stateNext = two;
					holdFromDec = 1'b1;
				end
				else if (deliver)
					stateNext = empty;
			end
			two:
			begin
				// older item moves up first so order is kept
				if (deliver)
				begin
					outFromHold = 1'b1;
					holdFromDec = accept;
					if (!accept)
						stateNext = one;
				end
			end
			default:
				stateNext = empty;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (rst)
			state <= empty;
		else
			state <= stateNext;
	end

	always_ff @(posedge clock)
	begin
		if (outFromDec)
			outReg <= decoded;
		else if (outFromHold)
			outReg <= holdReg;
		if (holdFromDec)
			holdReg <= decoded;
	end

	// a stalled texel is neither dropped nor changed
	assert property (@(posedge clock) disable iff (rst)
		texValid && !texReady |=> texValid && $stable(texData));

	// a refused request keeps its payload until it is taken
	assert property (@(posedge clock) disable iff (rst)
		reqValid && !reqReady |=> reqValid && $stable(reqBlock) && $stable(reqIndex)
			&& $stable(reqFormat));

endmodule

`default_nettype wire

//--- hw/utxTop.sv
// utxTop: configuration registers joined to the texel pipeline
`timescale 1ns/1ps
`default_nettype none

module utxTop
	import utxPkg::*;
(
	input wire clock,
	input wire rst,
	input wire cfgWrite,
	input wire cfgAddrT cfgAddr,
	input wire cfgDataT cfgData,
	output cfgDataT cfgReadData,
	input wire reqValid,
	input wire blockWord reqBlock,
	input wire pixIndex reqIndex,
	input wire reqFormat,
	output logic reqReady,
	output logic texValid,
	output texelWord texData,
	input wire texReady
);

	wire utx2Enable;
	wire interpEnable;
	wire texDone;

	utxModeRegs i_utxModeRegs
	(
		.clock(clock),
		.rst(rst),
		.cfgWrite(cfgWrite),
		.cfgAddr(cfgAddr),
		.cfgData(cfgData),
		.texDone(texDone),
		.cfgReadData(cfgReadData),
		.utx2Enable(utx2Enable),
		.interpEnable(interpEnable)
	);

	utxTexelUnit i_utxTexelUnit
	(
		.clock(clock),
		.rst(rst),
		.utx2Enable(utx2Enable),
		.interpEnable(interpEnable),
		.reqValid(reqValid),
		.reqBlock(reqBlock),
		.reqIndex(reqIndex),
		.reqFormat(reqFormat),
		.texReady(texReady),
		.reqReady(reqReady),
		.texValid(texValid),
		.texData(texData),
		.texDone(texDone)
	);

endmodule

`default_nettype wire

//--- verif/utxTopTb.sv
// utxTopTb: file-driven testbench for utxTop with a request driver, texel checker and back-pressure
`timescale 1ns/1ps
`default_nettype none

module utxTopTb
	import utxPkg::*;
();

	localparam int timeoutCycles = 200;

	logic clock;
	logic rst;
	logic cfgWrite;
	cfgAddrT cfgAddr;
	cfgDataT cfgData;
	cfgDataT cfgReadData;
	logic reqValid;
	blockWord reqBlock;
	pixIndex reqIndex;
	logic reqFormat;
	logic reqReady;
	logic texValid;
	texelWord texData;
	logic texReady;

	// expected texels in request order
	texelWord expectQ[$];
	texelWord expTexel;
	logic [31:0] lcgState;
	logic requestSeen;
	logic timedOut;
	logic fileError;
	int texErrors;
	int texChecks;
	int cfgErrors;
	int cfgChecks;

	// fields of one stimulus line
	int fd;
	int code;
	logic [7:0] cmd;
	logic [8*160-1:0] lineBuf;
	blockWord fBlock;
	pixIndex fIndex;
	logic fFormat;
	texelWord fTexel;
	cfgAddrT fAddr;
	cfgDataT fData;

	utxTop i_utxTop
	(
		.clock(clock),
		.rst(rst),
		.cfgWrite(cfgWrite),
		.cfgAddr(cfgAddr),
		.cfgData(cfgData),
		.cfgReadData(cfgReadData),
		.reqValid(reqValid),
		.reqBlock(reqBlock),
		.reqIndex(reqIndex),
		.reqFormat(reqFormat),
		.reqReady(reqReady),
		.texValid(texValid),
		.texData(texData),
		.texReady(texReady)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [31:0] nextRand(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// texReady high about three cycles in four
	initial
	begin
		texReady = 1'b0;
		lcgState = 32'haa29_0e8e;
		forever
		begin
			@(negedge clock);
			lcgState = nextRand(lcgState);
			texReady = (lcgState[31:30] != 2'b00);
		end
	end

	task automatic waitDrained();
		int waited;
		waited = 0;
		while (expectQ.size() != 0 && !timedOut)
		begin
			@(negedge clock);
			waited++;
			if (waited > timeoutCycles)
			begin
				$display("timeout: %0d texels still outstanding after %0d cycles",
					expectQ.size(), timeoutCycles);
				timedOut = 1'b1;
			end
		end
	endtask

	task automatic sendRequest(input blockWord block, input pixIndex index, input logic format,
		input texelWord expected);
		int waited;
		logic accepted;
		@(negedge clock);
		cfgWrite = 1'b0;
		reqValid = 1'b1;
		reqBlock = block;
		reqIndex = index;
		reqFormat = format;
		requestSeen = 1'b1;
		expectQ.push_back(expected);
		waited = 0;
		accepted = 1'b0;
		// payload stays put until the edge that takes it
		while (!accepted && !timedOut)
		begin
			@(posedge clock);
			if (reqReady)
				accepted = 1'b1;
			else
			begin
				waited++;
				if (waited > timeoutCycles)
				begin
					$display("timeout: reqReady stayed low for %0d cycles", timeoutCycles);
					timedOut = 1'b1;
				end
			end
		end
	endtask

	task automatic writeConfig(input cfgAddrT addr, input cfgDataT data);
		@(negedge clock);
		reqValid = 1'b0;
		cfgWrite = 1'b1;
		cfgAddr = addr;
		cfgData = data;
		@(posedge clock);
	endtask

	task automatic checkReadback(input cfgAddrT addr, input cfgDataT expected);
		@(negedge clock);
		reqValid = 1'b0;
		cfgWrite = 1'b0;
		// status count only settles once every texel is out
		waitDrained();
		cfgAddr = addr;
		@(posedge clock);
		cfgChecks++;
		assert (cfgReadData == expected)
		else
		begin
			cfgErrors++;
			$display("error at %0t: register %0d reads %h, expected %h",
				$time, addr, cfgReadData, expected);
		end
	endtask

	task automatic badLine();
		$display("stimulus line for command %s could not be parsed", cmd);
		fileError = 1'b1;
	endtask

	// texel checker, in order of delivery
	always @(posedge clock)
	begin
		if (!rst)
		begin
			if (!requestSeen)
			begin
				assert (!texValid)
				else
				begin
					texErrors++;
					$display("error at %0t: texValid high before any request", $time);
				end
			end
			if (texValid && texReady)
			begin
				texChecks++;
				assert (expectQ.size() != 0)
				else
				begin
					texErrors++;
					$display("error at %0t: texel %h delivered with none expected", $time, texData);
				end
				if (expectQ.size() != 0)
				begin
					expTexel = expectQ.pop_front();
					assert (texData == expTexel)
					else
					begin
						texErrors++;
						$display("error at %0t: texel %h, expected %h", $time, texData, expTexel);
					end
				end
			end
		end
	end

	initial
	begin
		rst = 1'b1;
		cfgWrite = 1'b0;
		cfgAddr = addrMode;
		cfgData = '0;
		reqValid = 1'b0;
		reqBlock = '0;
		reqIndex = '0;
		reqFormat = fmtUtx1;
		requestSeen = 1'b0;
		timedOut = 1'b0;
		fileError = 1'b0;
		texErrors = 0;
		texChecks = 0;
		cfgErrors = 0;
		cfgChecks = 0;
		repeat (8) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;

		fd = $fopen("verif/utxStimulus.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the stimulus file verif/utxStimulus.txt");
			fileError = 1'b1;
		end
		else
		begin
			code = $fscanf(fd, " %c", cmd);
			while (code == 1 && !timedOut)
			begin
				case (cmd)
					"#":
						code = $fgets(lineBuf, fd);
					"W":
					begin
						code = $fscanf(fd, "%h %h", fAddr, fData);
						if (code == 2)
							writeConfig(fAddr, fData);
						else
							badLine();
					end
					"R":
					begin
						code = $fscanf(fd, "%h %h", fAddr, fData);
						if (code == 2)
							checkReadback(fAddr, fData);
						else
							badLine();
					end
					"Q":
					begin
						code = $fscanf(fd, "%h %h %h %h", fBlock, fIndex, fFormat, fTexel);
						if (code == 4)
							sendRequest(fBlock, fIndex, fFormat, fTexel);
						else
							badLine();
					end
					default:
						badLine();
				endcase
				code = $fscanf(fd, " %c", cmd);
			end
			$fclose(fd);
		end

		@(negedge clock);
		reqValid = 1'b0;
		cfgWrite = 1'b0;
		waitDrained();
		$display("texel checks %0d, texel errors %0d, register checks %0d, register errors %0d",
			texChecks, texErrors, cfgChecks, cfgErrors);
		if (texErrors == 0 && cfgErrors == 0 && texChecks > 0 && !timedOut && !fileError)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/utxStimulus.txt
# W addr data | R addr expected | Q block index format texel
# all fields hex, format 0 is UTX1 and 1 is UTX2
# reset values
R 0 03
R 1 00
# UTX1 zero spread
Q 000000005A5A0369 1 0 FFFF333366669999
# UTX1 wrapping spread, high then low selector
Q DEADBEEF00FFF1E0 3 0 FFFF90906D6D7F7F
Q DEADBEEF00FFF1E0 C 0 FFFF92926F6F8181
Q 000000008001682C F 0 FFFFBBBB5555FFFF
Q 000000008001682C 7 0 FFFF5555EFEF9999
# UTX2 opaque, interpolated codes 00 11 10 01
Q 0000006C03E47C10 0 1 FFFF0000FFFF2121
Q 0000006C03E47C10 1 1 FFFFFFFF00008484
Q 0000006C03E47C10 2 1 FFFF4F4FAFAF3F3F
Q 0000006C03E47C10 3 1 FFFFAFAF4F4F6565
# UTX2 alpha mode, interpolated codes 00 11 10 01
Q 00006C008B7ED587 4 1 40401010DEDEF7F7
Q 00006C008B7ED587 5 1 A0A0ADAD63633939
Q 00006C008B7ED587 6 1 60604141B7B7BBBB
Q 00006C008B7ED587 7 1 86867B7B89897474
R 1 0D
# interpolation off, two-level rule
W 0 01
R 0 01
Q 00006C008B7ED587 4 1 40401010DEDEF7F7
Q 00006C008B7ED587 5 1 A0A0ADAD63633939
Q 00006C008B7ED587 6 1 4040ADAD63633939
Q 00006C008B7ED587 7 1 A0A01010DEDEF7F7
Q 0000006C03E47C10 2 1 FFFFFFFF00008484
Q 0000006C03E47C10 3 1 FFFF0000FFFF2121
# UTX2 off gives zero, UTX1 unaffected
W 0 02
Q 0000006C03E47C10 2 1 0000000000000000
Q DEADBEEF00FFF1E0 3 0 FFFF90906D6D7F7F
# status ignores writes, unused mode bits masked
W 1 55
W 0 FF
R 0 03
# back-to-back burst
Q 0000006C03E47C10 2 1 FFFF4F4FAFAF3F3F
Q 00006C008B7ED587 7 1 86867B7B89897474
Q 000000008001682C 0 0 FFFFBBBB5555FFFF
Q DEADBEEF00FFF1E0 C 0 FFFF92926F6F8181
Q 00006C008B7ED587 6 1 60604141B7B7BBBB
Q 0000006C03E47C10 1 1 FFFFFFFF00008484
R 1 1B

//--- sources.f
hw/utxPkg.sv
hw/utxInterp.sv
hw/utxPixelDecode.sv
hw/utxModeRegs.sv
hw/utxTexelUnit.sv
hw/utxTop.sv
verif/utxTopTb.sv

//--- runSim.sh
#!/bin/sh
# build and run the texel unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module utxTopTb \
	-Mdir obj_dir -o utxSim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/utxSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "Regression failed" sim.log; then
	exit 1
fi
exit 0
